//--- Makefile
# Verilator build and run for the vector unit

VERILATOR ?= verilator
TOP       ?= vector_unit_tb
LINT_TOP  ?= vector_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
source/vector_isa_pkg.sv
source/vector_lane_pkg.sv
source/lane_regfile.sv
source/lane_alu.sv
source/lane_unit.sv
source/vector_unit.sv
sim/vector_unit_tb.sv

//--- sim/vector_unit_tb.sv
// Testbench for the vector unit; replays the test data file and checks against a register model
`timescale 1ns/1ps
`default_nettype none

module vector_unit_tb;
	import vector_isa_pkg::*;
	import vector_lane_pkg::*;

	localparam int LANES           = vector_lane_pkg::NUM_LANES;
	localparam int CYCLES_PER_LINE = 40;

	logic       clock = 1'b0;
	logic       reset;
	command_t   command;
	lane_mask_t lane_enable;
	data_t      scalar_in;
	logic       commit_grant;
	logic       cmd_ready;
	logic       commit_req;
	data_t      scalar_out;
	lane_mask_t status;

	data_t model [LANES][NUM_REGS];		// Expected register contents
	int    errors;
	int    checks;
	int    timeout_cycles = 0;

	always #5 clock = ~clock;

	vector_unit #(
		.NUM_LANES  (LANES),
		.DATA_WIDTH (DATA_WIDTH)
	) u_vector_unit (
		.clock        (clock),
		.reset        (reset),
		.command      (command),
		.lane_enable  (lane_enable),
		.scalar_in    (scalar_in),
		.commit_grant (commit_grant),
		.cmd_ready    (cmd_ready),
		.commit_req   (commit_req),
		.scalar_out   (scalar_out),
		.status       (status)
	);

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic check_data(input string name, input data_t expected, input data_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_mask(input string name, input lane_mask_t expected,
			input lane_mask_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	task automatic decode_opcode(input string mnemonic, output opcode_t op, output logic known);
		known = 1'b1;
		case (mnemonic)
			"nop":   op = op_nop;
			"add":   op = op_add;
			"sub":   op = op_sub;
			"mul":   op = op_mul;
			"mac":   op = op_mac;
			"movs":  op = op_movs;
			"lid":   op = op_lid;
			"rot":   op = op_rot;
			"read":  op = op_read;
			default: begin
				op    = op_nop;
				known = 1'b0;
			end
		endcase
	endtask

	// Reference rules applied to all lanes from the old state
	task automatic apply_to_model(input lane_mask_t mask, input command_t cmd, input data_t scalar);
		data_t next [LANES];
		logic  writes;
		writes = !(cmd.opcode inside {op_nop, op_read});
		for (int i = 0; i < LANES; i++) begin
			case (cmd.opcode)
				op_add:  next[i] = model[i][cmd.src1] + model[i][cmd.src2];
				op_sub:  next[i] = model[i][cmd.src1] - model[i][cmd.src2];
				op_mul:  next[i] = model[i][cmd.src1] * model[i][cmd.src2];
				op_mac:  next[i] = model[i][cmd.src1] * model[i][cmd.src2] + model[i][cmd.src3];
				op_movs: next[i] = scalar;
				op_lid:  next[i] = data_t'(i);
				op_rot:  next[i] = model[(i + 1) % LANES][cmd.src1] + model[i][cmd.src2];
				default: next[i] = '0;
			endcase
		end
		for (int i = 0; i < LANES; i++) begin
			if (writes && mask[i]) begin
				model[i][cmd.dst] = next[i];
			end
		end
	endtask

	////////////////////////////////////////
	// Bus sequences
	////////////////////////////////////////
	task automatic issue_command(input command_t cmd, input lane_mask_t mask, input data_t scalar);
		@(posedge clock);
		command     <= cmd;
		lane_enable <= mask;
		scalar_in   <= scalar;
		@(negedge clock);
		while (!cmd_ready) @(negedge clock);
		@(posedge clock);		// Accept edge
		command.valid <= 1'b0;
	endtask

	task automatic commit_command(input string name, input lane_mask_t mask);
		int delay;
		delay = $urandom % 6;		// Grant delay 0 to 5 cycles
		@(negedge clock);
		check_flag($sformatf("%s ready_busy", name), 1'b0, cmd_ready);
		while (!commit_req) @(negedge clock);
		check_mask($sformatf("%s status", name), mask, status);
		repeat (delay) begin
			@(negedge clock);
			check_flag($sformatf("%s req_held", name), 1'b1, commit_req);
			check_flag($sformatf("%s ready_held", name), 1'b0, cmd_ready);
		end
		@(posedge clock);
		commit_grant <= 1'b1;
		@(negedge clock);
		check_flag($sformatf("%s ready_grant", name), 1'b0, cmd_ready);
		@(posedge clock);		// Write-back edge
		commit_grant <= 1'b0;
		@(negedge clock);
		check_flag($sformatf("%s req_drop", name), 1'b0, commit_req);
		check_mask($sformatf("%s status_drop", name), '0, status);
		check_flag($sformatf("%s ready_back", name), 1'b1, cmd_ready);
	endtask

	task automatic read_register(input string name, input int lane, input int idx,
			input data_t expected);
		command_t cmd;
		cmd        = '0;
		cmd.valid  = 1'b1;
		cmd.opcode = op_read;
		cmd.src1   = reg_idx_t'(idx);
		issue_command(cmd, '1, data_t'(lane));
		commit_command(name, '1);
		@(posedge clock);
		scalar_in <= data_t'(lane);		// Lane select for the readout
		@(negedge clock);
		check_data(name, expected, scalar_out);
		check_data($sformatf("%s model", name), model[lane][idx], scalar_out);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		int         fd;
		int         lines;
		int         count;
		int         dst;
		int         src1;
		int         src2;
		int         src3;
		string      kind;
		string      name;
		string      mnemonic;
		string      rest;
		lane_mask_t mask;
		data_t      value;
		command_t   cmd;
		opcode_t    op;
		logic       known;
		void'($urandom(32'ha4d4_2f83));
		reset        = 1'b1;
		command      = '0;
		lane_enable  = '0;
		scalar_in    = '0;
		commit_grant = 1'b0;
		errors       = 0;
		checks       = 0;
		lines        = 0;
		for (int i = 0; i < LANES; i++) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				model[i][r] = '0;
			end
		end
		fd = $fopen("sim/vector_unit_testdata.txt", "r");
		if (fd == 0) begin
			report_failure("the test data file could not be opened");
		end else begin
			while ($fgets(rest, fd) != 0) lines++;
			$fclose(fd);
			timeout_cycles = (lines + 1) * CYCLES_PER_LINE;
			fd = $fopen("sim/vector_unit_testdata.txt", "r");
			repeat (5) @(posedge clock);
			reset <= 1'b0;
			@(negedge clock);
			check_flag("reset commit_req", 1'b0, commit_req);
			check_mask("reset status", '0, status);
			check_flag("reset cmd_ready", 1'b1, cmd_ready);
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "C") begin
					count = $fscanf(fd, "%s %h %s %d %d %d %d %h", name, mask, mnemonic,
						dst, src1, src2, src3, value);
					decode_opcode(mnemonic, op, known);
					if (count != 8 || !known) begin
						report_failure($sformatf("command line %s could not be parsed", name));
					end else begin
						cmd        = '0;
						cmd.valid  = 1'b1;
						cmd.opcode = op;
						cmd.dst    = reg_idx_t'(dst);
						cmd.src1   = reg_idx_t'(src1);
						cmd.src2   = reg_idx_t'(src2);
						cmd.src3   = reg_idx_t'(src3);
						issue_command(cmd, mask, value);
						commit_command(name, mask);
						apply_to_model(mask, cmd, value);
					end
				end else if (kind == "R") begin
					count = $fscanf(fd, "%s %d %d %h", name, dst, src1, value);
					if (count != 4) begin
						report_failure($sformatf("readout line %s could not be parsed", name));
					end else begin
						read_register(name, dst, src1, value);
					end
				end else if (kind.substr(0, 0) == "#") begin
					count = $fgets(rest, fd);		// Skip comment text
				end else begin
					report_failure($sformatf("unknown line kind %s in the test data", kind));
				end
			end
			$fclose(fd);
		end
		$display("Errors: %0d of %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog armed once the data file has been sized
	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clock);
		$display("Error: timeout, the test data did not finish within %0d cycles", timeout_cycles);
		$display("Errors: %0d of %0d checks", errors + 1, checks);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/vector_unit_testdata.txt
# C name mask(hex) opcode dst src1 src2 src3 scalar(hex)
# R name lane register expected(hex)
R reset_l0_r0 0 0 00000000
R reset_l3_r7 3 7 00000000
C lid_all f lid 1 0 0 0 00000000
R lid_l0 0 1 00000000
R lid_l3 3 1 00000003
C movs_all f movs 2 0 0 0 00000010
R movs_l2 2 2 00000010
C add_all f add 3 1 2 0 00000000
R add_l1 1 3 00000011
C movs_big f movs 4 0 0 0 ffffffff
C add_wrap f add 5 4 2 0 00000000
R add_wrap_l0 0 5 0000000f
C sub_all f sub 6 1 2 0 00000000
R sub_l0 0 6 fffffff0
R sub_l3 3 6 fffffff3
C mul_wrap f mul 6 4 2 0 00000000
R mul_wrap_l2 2 6 fffffff0
C mac_all f mac 7 3 2 1 00000000
R mac_l2 2 7 00000122
C rot_all f rot 0 1 3 0 00000000
R rot_l3 3 0 00000013
R rot_l1 1 0 00000013
C nop_all f nop 0 0 0 0 00000000
R nop_keep_l0 0 0 00000011
C mask_movs 5 movs 1 0 0 0 000000aa
R mask_l0 0 1 000000aa
R mask_l1 1 1 00000001
R mask_l3 3 1 00000003
C mask_rot a rot 2 1 0 0 00000000
R mask_rot_l1 1 2 000000bd
R mask_rot_l2 2 2 00000010
R mask_rot_l3 3 2 000000bd

//--- source/lane_alu.sv
// Combinational lane arithmetic; instantiated once inside every lane
`timescale 1ns/1ps
`default_nettype none

module lane_alu #(
	parameter int DATA_WIDTH = vector_lane_pkg::DATA_WIDTH,
	parameter int LANE_ID    = 0
) (
	input  wire vector_isa_pkg::opcode_t opcode,
	input  wire vector_lane_pkg::data_t  operand_a,		// src1, or neighbour src1 on rotate
	input  wire vector_lane_pkg::data_t  operand_b,
	input  wire vector_lane_pkg::data_t  operand_c,
	input  wire vector_lane_pkg::data_t  scalar_in,
	output vector_lane_pkg::data_t  result,
	output logic                    writes		// Opcode writes a register
);
	import vector_isa_pkg::*;
	import vector_lane_pkg::*;

	logic [DATA_WIDTH-1:0] a;
	logic [DATA_WIDTH-1:0] b;
	logic [DATA_WIDTH-1:0] c;
	logic [DATA_WIDTH-1:0] sum;
	logic [DATA_WIDTH-1:0] diff;
	logic [DATA_WIDTH-1:0] product;		// Low half only
	logic [DATA_WIDTH-1:0] mac;

	assign a = operand_a[DATA_WIDTH-1:0];
	assign b = operand_b[DATA_WIDTH-1:0];
	assign c = operand_c[DATA_WIDTH-1:0];

	assign sum     = a + b;
	assign diff    = a - b;
	assign product = a * b;		// Wraps at DATA_WIDTH
	assign mac     = product + c;

	////////////////////////////////////////
	// Result select
	////////////////////////////////////////
	always_comb begin
		result = '0;
		writes = 1'b1;
		case (opcode)
			op_add:  result = data_t'(sum);
			op_rot:  result = data_t'(sum);		// Operand A already swapped
			op_sub:  result = data_t'(diff);
			op_mul:  result = data_t'(product);
			op_mac:  result = data_t'(mac);
			op_movs: result = scalar_in;
			op_lid:  result = data_t'(LANE_ID);
			op_read: begin
				result = operand_a;		// Not written back
				writes = 1'b0;
			end
			default: begin
				result = '0;		// Nop and unused codes
				writes = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/lane_regfile.sv
// Per-lane register file with three synchronous read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module lane_regfile (
	input  wire                      clock,
	input  wire                      reset,
	input  wire vector_isa_pkg::reg_idx_t rd_idx1,
	input  wire vector_isa_pkg::reg_idx_t rd_idx2,
	input  wire vector_isa_pkg::reg_idx_t rd_idx3,
	input  wire                      wr_en,
	input  wire vector_isa_pkg::reg_idx_t wr_idx,
	input  wire vector_lane_pkg::data_t   wr_data,
	output vector_lane_pkg::data_t   rd_data1,
	output vector_lane_pkg::data_t   rd_data2,
	output vector_lane_pkg::data_t   rd_data3
);
	import vector_isa_pkg::*;
	import vector_lane_pkg::*;

	data_t regs [NUM_REGS];		// Register storage

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////
	// Same-edge write is not forwarded, old value wins
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_data1 <= '0;
			rd_data2 <= '0;
			rd_data3 <= '0;
		end else begin
			rd_data1 <= regs[rd_idx1];
			rd_data2 <= regs[rd_idx2];
			rd_data3 <= regs[rd_idx3];
		end
	end

endmodule

`default_nettype wire

//--- source/lane_unit.sv
// One execution lane: operand read, neighbour select, pending result and commit flag
`timescale 1ns/1ps
`default_nettype none

module lane_unit #(
	parameter int NUM_LANES  = vector_lane_pkg::NUM_LANES,
	parameter int DATA_WIDTH = vector_lane_pkg::DATA_WIDTH,
	parameter int LANE_ID    = 0
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           enable,		// This lane takes part
	input  wire                           accept,		// Command handshake at the top
	input  wire vector_isa_pkg::command_t  command,
	input  wire vector_lane_pkg::data_t    scalar_in,
	input  wire                           commit_grant,
	input  wire vector_lane_pkg::lane_bus_t lane_bus_in,
	output vector_lane_pkg::data_t        src1_out,		// Published to the neighbour
	output vector_lane_pkg::data_t        readout,
	output logic                          commit,
	output logic                          status
);
	import vector_isa_pkg::*;
	import vector_lane_pkg::*;

	localparam int NEXT_LANE = (LANE_ID + 1) % NUM_LANES;

	typedef enum logic {
		st_idle,
		st_pending
	} commit_state_t;

	commit_state_t state;
	command_t      cmd_q;
	logic          exec_q;		// Operands valid this cycle
	data_t         scalar_q;
	data_t         rd_data1;
	data_t         rd_data2;
	data_t         rd_data3;
	data_t         operand_a;
	data_t         alu_result;
	logic          alu_writes;
	data_t         pend_data;
	reg_idx_t      pend_dst;
	logic          pend_writes;
	data_t         readout_q;
	logic          wr_en;

	////////////////////////////////////////
	// Operand read stage
	////////////////////////////////////////
	lane_regfile u_regfile (
		.clock    (clock),
		.reset    (reset),
		.rd_idx1  (command.src1),
		.rd_idx2  (command.src2),
		.rd_idx3  (command.src3),
		.wr_en    (wr_en),
		.wr_idx   (pend_dst),
		.wr_data  (pend_data),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.rd_data3 (rd_data3)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			exec_q <= 1'b0;
		end else begin
			exec_q <= accept && enable;
		end
	end

	always_ff @(posedge clock) begin
		if (accept && enable) begin
			cmd_q    <= command;
			scalar_q <= scalar_in;		// Source may move on after accept
		end
	end

	assign src1_out  = rd_data1;
	assign operand_a = (cmd_q.opcode == op_rot) ? lane_bus_in[NEXT_LANE] : rd_data1;

	lane_alu #(
		.DATA_WIDTH (DATA_WIDTH),
		.LANE_ID    (LANE_ID)
	) u_alu (
		.opcode    (cmd_q.opcode),
		.operand_a (operand_a),
		.operand_b (rd_data2),
		.operand_c (rd_data3),
		.scalar_in (scalar_q),
		.result    (alu_result),
		.writes    (alu_writes)
	);

	////////////////////////////////////////
	// Pending result and commit
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= st_idle;
			readout_q <= '0;
		end else begin
			if (exec_q) begin
				state <= st_pending;
				if (cmd_q.opcode == op_read) begin
					readout_q <= rd_data1;
				end
			end else if (state == st_pending && commit_grant) begin
				state <= st_idle;		// Write-back happens on this edge
			end
		end
	end

	always_ff @(posedge clock) begin
		if (exec_q) begin
			pend_data   <= alu_result;
			pend_dst    <= cmd_q.dst;
			pend_writes <= alu_writes;
		end
	end

	assign wr_en   = (state == st_pending) && commit_grant && pend_writes;
	assign commit  = (state == st_pending);
	assign status  = (state == st_pending);
	assign readout = readout_q;

	// The top must hold off new commands until this lane has committed
	assert property (@(posedge clock) disable iff (reset)
		(accept && enable) |-> (state == st_idle && !exec_q));

endmodule

`default_nettype wire

//--- source/vector_isa_pkg.sv
// Command encoding shared by every lane; imported by the lane logic and the top level
`default_nettype none

package vector_isa_pkg;

	////////////////////////////////////////
	// Register file geometry
	////////////////////////////////////////
	localparam int NUM_REGS      = 8;
	localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);

	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;		// Register index

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////
	typedef enum logic [3:0] {
		op_nop  = 4'h0,		// Commit only, no write
		op_add  = 4'h1,
		op_sub  = 4'h2,
		op_mul  = 4'h3,
		op_mac  = 4'h4,		// src1 * src2 + src3
		op_movs = 4'h5,		// Load scalar input
		op_lid  = 4'h6,		// Load own lane index
		op_rot  = 4'h7,		// Neighbour src1 + own src2
		op_read = 4'h8		// Latch src1 for readout
	} opcode_t;

	// Broadcast command, same for all lanes
	typedef struct packed {
		logic     valid;
		opcode_t  opcode;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		reg_idx_t src3;
	} command_t;

endpackage

`default_nettype wire

//--- source/vector_lane_pkg.sv
// Data and lane-array types for the vector unit; imported wherever lane data is carried
`default_nettype none

package vector_lane_pkg;

	////////////////////////////////////////
	// Default geometry
	////////////////////////////////////////
	localparam int DATA_WIDTH = 32;		// Overridden from the top level
	localparam int NUM_LANES  = 4;		// Overridden from the top level

	typedef logic [DATA_WIDTH-1:0] data_t;		// One lane data word

	typedef logic [NUM_LANES-1:0] lane_mask_t;		// Enables and status, bit per lane

	// One word per lane, used for the neighbour
	// source-1 bus and the readout collection
	typedef data_t [NUM_LANES-1:0] lane_bus_t;

endpackage

`default_nettype wire

//--- source/vector_unit.sv
// Top level of the SIMT vector unit; drives broadcast commands into the lane array
`timescale 1ns/1ps
`default_nettype none

module vector_unit #(
	parameter int NUM_LANES  = vector_lane_pkg::NUM_LANES,
	parameter int DATA_WIDTH = vector_lane_pkg::DATA_WIDTH
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire vector_isa_pkg::command_t  command,
	input  wire vector_lane_pkg::lane_mask_t lane_enable,
	input  wire vector_lane_pkg::data_t    scalar_in,		// Also the readout lane select
	input  wire                           commit_grant,
	output logic                          cmd_ready,
	output logic                          commit_req,
	output vector_lane_pkg::data_t        scalar_out,
	output wire vector_lane_pkg::lane_mask_t status
);
	import vector_lane_pkg::*;

	localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic       accept;
	logic       issue_q;		// Command in the operand stage
	lane_mask_t enable_q;		// Lanes of the command in flight
	wire lane_mask_t commit_flags;
	wire lane_bus_t  lane_bus;
	wire lane_bus_t  readout_bus;

	////////////////////////////////////////
	// Command handshake
	////////////////////////////////////////
	assign accept    = command.valid && cmd_ready;
	assign cmd_ready = !issue_q && !(|status);

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_q  <= 1'b0;
			enable_q <= '0;
		end else begin
			issue_q <= accept;
			if (accept) begin
				enable_q <= lane_enable;
			end
		end
	end

	// All enabled lanes done, and at least one lane in play
	assign commit_req = (|enable_q) && (commit_flags == enable_q);

	assign scalar_out = readout_bus[scalar_in[LANE_BITS-1:0]];

	////////////////////////////////////////
	// Lane array
	////////////////////////////////////////
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.NUM_LANES  (NUM_LANES),
			.DATA_WIDTH (DATA_WIDTH),
			.LANE_ID    (i)
		) u_lane (
			.clock        (clock),
			.reset        (reset),
			.enable       (lane_enable[i]),
			.accept       (accept),
			.command      (command),
			.scalar_in    (scalar_in),
			.commit_grant (commit_grant),
			.lane_bus_in  (lane_bus),
			.src1_out     (lane_bus[i]),
			.readout      (readout_bus[i]),
			.commit       (commit_flags[i]),
			.status       (status[i])
		);
	end

	// Grant only answers an outstanding request
	assert property (@(posedge clock) disable iff (reset) commit_grant |-> commit_req);

endmodule

`default_nettype wire
